// File: source/matmul_defines.svh
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// rows and columns of the array, and of both square matrices.
`define MATMUL_DIM 4

// unsigned operand width.
`define MATMUL_OPW 8

// accumulator width, products wrap at this size.
`define MATMUL_ACCW 32

// Wishbone byte address width.
`define MATMUL_ADRW 8

`endif

// File: source/matmulPkg.sv
`default_nettype none

`include "matmul_defines.svh"

package matmulPkg;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`MATMUL_ADRW-1:0] adr;
        logic [31:0]             dat;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

    typedef struct packed {
        logic                   valid;
        logic [`MATMUL_OPW-1:0] data;
    } opLane_t;

    typedef opLane_t [`MATMUL_DIM-1:0] laneVec_t; // one lane per row or column edge.

    typedef logic [`MATMUL_DIM-1:0][`MATMUL_DIM-1:0][`MATMUL_OPW-1:0]  opMatrix_t; // [row][col].
    typedef logic [`MATMUL_DIM-1:0][`MATMUL_DIM-1:0][`MATMUL_ACCW-1:0] accGrid_t;

    // register map, byte addresses with a word stride.
    localparam logic [`MATMUL_ADRW-1:0] CTRL_ADR   = 'h00;
    localparam logic [`MATMUL_ADRW-1:0] STATUS_ADR = 'h04;
    localparam logic [`MATMUL_ADRW-1:0] A_BASE     = 'h40;
    localparam logic [`MATMUL_ADRW-1:0] B_BASE     = 'h80;
    localparam logic [`MATMUL_ADRW-1:0] C_BASE     = 'hC0;

endpackage

`default_nettype wire

// File: source/skewLine.sv
`timescale 1ns/100ps
`default_nettype none

module skewLine #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    generate
        if (DEPTH == 0) begin : gNoDelay
            assign dout = din;
        end else begin : gDelay
            payload_t stages [DEPTH];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < DEPTH; s++) begin
                        stages[s] <= '0;
                    end
                end else begin
                    stages[0] <= din;
                    for (int s = 1; s < DEPTH; s++) begin
                        stages[s] <= stages[s-1]; // one cycle per stage.
                    end
                end
            end

            assign dout = stages[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

// File: source/macCell.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_defines.svh"

module macCell (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clearAcc,
    input  matmulPkg::opLane_t       west,
    input  matmulPkg::opLane_t       north,
    output matmulPkg::opLane_t       east,
    output matmulPkg::opLane_t       south,
    output logic [`MATMUL_ACCW-1:0]  acc
);

    logic [2*`MATMUL_OPW-1:0] product;
    logic                     both;

    assign product = west.data * north.data;
    assign both    = west.valid && north.valid; // operands of the same beat meet here.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            east  <= '0;
            south <= '0;
        end else begin
            east  <= west;
            south <= north;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clearAcc) begin
            acc <= '0;
        end else if (both) begin
            acc <= acc + `MATMUL_ACCW'(product); // wraps at the accumulator width.
        end
    end

endmodule

`default_nettype wire

// File: source/systolicArray.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_defines.svh"

module systolicArray (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clearAcc,
    input  matmulPkg::laneVec_t  rowLanes,
    input  matmulPkg::laneVec_t  colLanes,
    output matmulPkg::accGrid_t  accs
);

    localparam int DIM = `MATMUL_DIM;

    // horizontal links carry A eastward, vertical links carry B southward.
    matmulPkg::opLane_t hLink [DIM][DIM+1];
    matmulPkg::opLane_t vLink [DIM+1][DIM];

    generate
        for (genvar i = 0; i < DIM; i++) begin : gRowSkew
            skewLine #(
                .payload_t (matmulPkg::opLane_t),
                .DEPTH     (i)
            ) uRowSkew (
                .clk   (clk),
                .rst_n (rst_n),
                .din   (rowLanes[i]),
                .dout  (hLink[i][0])
            );
        end

        for (genvar j = 0; j < DIM; j++) begin : gColSkew
            skewLine #(
                .payload_t (matmulPkg::opLane_t),
                .DEPTH     (j)
            ) uColSkew (
                .clk   (clk),
                .rst_n (rst_n),
                .din   (colLanes[j]),
                .dout  (vLink[0][j])
            );
        end

        for (genvar i = 0; i < DIM; i++) begin : gRow
            for (genvar j = 0; j < DIM; j++) begin : gCol
                macCell uCell (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .clearAcc (clearAcc),
                    .west     (hLink[i][j]),
                    .north    (vLink[i][j]),
                    .east     (hLink[i][j+1]), // last column drives nothing.
                    .south    (vLink[i+1][j]),
                    .acc      (accs[i][j])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: source/matmulSequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_defines.svh"

module matmulSequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  matmulPkg::opMatrix_t matA,
    input  matmulPkg::opMatrix_t matB,
    output logic                 clearAcc,
    output matmulPkg::laneVec_t  rowLanes,
    output matmulPkg::laneVec_t  colLanes,
    output logic                 busy,
    output logic                 done
);

    localparam int DIM     = `MATMUL_DIM;
    localparam int RUN_LEN = 3 * DIM; // last product is in by this cycle.
    localparam int CW      = $clog2(RUN_LEN + 1);
    localparam int KW      = $clog2(DIM);

    logic [CW-1:0] cnt;
    logic          beat;
    logic [KW-1:0] beatIdx;

    // count value c is cycle c after start, beats leave in cycles 2..DIM+1.
    assign beat    = busy && (cnt != '0) && (cnt <= CW'(DIM));
    assign beatIdx = KW'(cnt - CW'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            clearAcc <= 1'b0;
        end else begin
            clearAcc <= start;
            if (start) begin
                cnt  <= CW'(1);
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy) begin
                if (cnt == CW'(RUN_LEN)) begin
                    cnt  <= '0;
                    busy <= 1'b0;
                    done <= 1'b1; // held until the next run starts.
                end else begin
                    cnt <= cnt + CW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowLanes <= '0;
            colLanes <= '0;
        end else begin
            for (int i = 0; i < DIM; i++) begin
                rowLanes[i].valid <= beat;
                rowLanes[i].data  <= beat ? matA[i][beatIdx] : '0; // column k of A.
            end
            for (int j = 0; j < DIM; j++) begin
                colLanes[j].valid <= beat;
                colLanes[j].data  <= beat ? matB[beatIdx][j] : '0; // row k of B.
            end
        end
    end

endmodule

`default_nettype wire

// File: source/matmulRegs.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_defines.svh"

module matmulRegs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matmulPkg::wbReq_t    wbIn,
    output matmulPkg::wbRsp_t    wbOut,
    input  logic                 busy,
    input  logic                 done,
    input  matmulPkg::accGrid_t  accs,
    output logic                 start,
    output matmulPkg::opMatrix_t matA,
    output matmulPkg::opMatrix_t matB
);

    localparam int DIM  = `MATMUL_DIM;
    localparam int ADRW = `MATMUL_ADRW;
    localparam int IDXW = $clog2(DIM * DIM);
    localparam int OFFW = IDXW + 2; // element index sits above the byte offset.

    logic            req;
    logic            wrEn;
    logic            aSel;
    logic            bSel;
    logic            cSel;
    logic [IDXW-1:0] idx;
    logic            ackQ;
    logic [31:0]     rdQ;
    logic [31:0]     rdData;

    assign req  = wbIn.cyc && wbIn.stb;
    assign wrEn = req && wbIn.we && ackQ; // data is taken while ack is high.
    assign idx  = wbIn.adr[OFFW-1:2];

    assign aSel = wbIn.adr[ADRW-1:OFFW] == matmulPkg::A_BASE[ADRW-1:OFFW];
    assign bSel = wbIn.adr[ADRW-1:OFFW] == matmulPkg::B_BASE[ADRW-1:OFFW];
    assign cSel = wbIn.adr[ADRW-1:OFFW] == matmulPkg::C_BASE[ADRW-1:OFFW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ackQ  <= 1'b0;
            start <= 1'b0;
        end else begin
            ackQ  <= req && !ackQ; // one-cycle ack, then drops under a held strobe.
            start <= wrEn && (wbIn.adr == matmulPkg::CTRL_ADR) && wbIn.dat[0] && !busy;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                if (wrEn && (idx == IDXW'(i * DIM + j))) begin
                    if (aSel) begin
                        matA[i][j] <= wbIn.dat[`MATMUL_OPW-1:0];
                    end
                    if (bSel) begin
                        matB[i][j] <= wbIn.dat[`MATMUL_OPW-1:0];
                    end
                end
            end
        end
    end

    always_comb begin
        rdData = '0;
        if (wbIn.adr == matmulPkg::STATUS_ADR) begin
            rdData = {30'b0, done, busy};
        end else begin
            for (int i = 0; i < DIM; i++) begin
                for (int j = 0; j < DIM; j++) begin
                    if (idx == IDXW'(i * DIM + j)) begin
                        if (aSel) begin
                            rdData = 32'(matA[i][j]);
                        end else if (bSel) begin
                            rdData = 32'(matB[i][j]);
                        end else if (cSel) begin
                            rdData = 32'(accs[i][j]);
                        end
                    end
                end
            end
        end
    end

    // read data is captured on the same edge that raises ack.
    always_ff @(posedge clk) begin
        if (req && !ackQ) begin
            rdQ <= rdData;
        end
    end

    assign wbOut.ack = ackQ;
    assign wbOut.dat = rdQ;

endmodule

`default_nettype wire

// File: source/matmulTop.sv
`timescale 1ns/100ps
`default_nettype none

module matmulTop (
    input  logic              clk,
    input  logic              rst_n,
    input  matmulPkg::wbReq_t wbIn,
    output matmulPkg::wbRsp_t wbOut
);

    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 clearAcc;
    matmulPkg::opMatrix_t matA;
    matmulPkg::opMatrix_t matB;
    matmulPkg::laneVec_t  rowLanes;
    matmulPkg::laneVec_t  colLanes;
    matmulPkg::accGrid_t  accs;

    matmulRegs uRegs (
        .clk   (clk),
        .rst_n (rst_n),
        .wbIn  (wbIn),
        .wbOut (wbOut),
        .busy  (busy),
        .done  (done),
        .accs  (accs),
        .start (start),
        .matA  (matA),
        .matB  (matB)
    );

    matmulSequencer uSequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .matA     (matA),
        .matB     (matB),
        .clearAcc (clearAcc),
        .rowLanes (rowLanes),
        .colLanes (colLanes),
        .busy     (busy),
        .done     (done)
    );

    systolicArray uArray (
        .clk      (clk),
        .rst_n    (rst_n),
        .clearAcc (clearAcc),
        .rowLanes (rowLanes),
        .colLanes (colLanes),
        .accs     (accs)
    );

endmodule

`default_nettype wire

// File: verif/tbWishboneTasks.svh
`ifndef TB_WISHBONE_TASKS_SVH
`define TB_WISHBONE_TASKS_SVH

// one classic cycle, entered and left 2 ns after a rising edge.
task automatic wbAccess(input logic write, input logic [`MATMUL_ADRW-1:0] adr,
                        input logic [31:0] wdat, output logic [31:0] rdat);
    int   waited;
    logic acked;
    waited   = 0;
    acked    = 1'b0;
    rdat     = '0;
    wbIn.cyc = 1'b1;
    wbIn.stb = 1'b1;
    wbIn.we  = write;
    wbIn.adr = adr;
    wbIn.dat = wdat;
    while (!acked && waited < ACK_TIMEOUT) begin
        @(posedge clk);
        #1;
        acked  = wbOut.ack;
        waited = waited + 1;
    end
    if (acked) begin
        rdat     = wbOut.dat; // read data is valid while ack is high.
        ackCycle = cycleCount;
    end else begin
        $display("ERROR: no Wishbone ack within %0d cycles at address 0x%02h", ACK_TIMEOUT, adr);
        errors = errors + 1;
    end
    @(posedge clk); // the slave takes write data on this edge.
    #2;
    wbIn = '0;
    @(posedge clk);
    #2;
endtask

task automatic wbWrite(input logic [`MATMUL_ADRW-1:0] adr, input logic [31:0] dat);
    logic [31:0] ignored;
    wbAccess(1'b1, adr, dat, ignored);
endtask

task automatic wbRead(input logic [`MATMUL_ADRW-1:0] adr, output logic [31:0] dat);
    wbAccess(1'b0, adr, 32'h0, dat);
endtask

`endif

// File: verif/tbMatmul.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_defines.svh"

module tbMatmul;

    localparam int DIM          = `MATMUL_DIM;
    localparam int ACK_TIMEOUT  = 20;
    localparam int POLL_TIMEOUT = 200;
    localparam int RUN_BOUND    = 3 * DIM + 1 + 5; // run length, handshake and one status poll.

    logic                 clk = 1'b0;
    logic                 rst_n;
    matmulPkg::wbReq_t    wbIn;
    matmulPkg::wbRsp_t    wbOut;

    int                   errors     = 0;
    int                   checks     = 0;
    int                   cycleCount = 0;
    int                   ackCycle   = 0;
    int                   seed       = 32'hcba8;
    int                   startAck;
    logic [31:0]          status;
    matmulPkg::opMatrix_t aMat;
    matmulPkg::opMatrix_t bMat;

    matmulTop u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .wbIn  (wbIn),
        .wbOut (wbOut)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    `include "tbWishboneTasks.svh"

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errors = errors + 1;
        end
    endtask

    function automatic logic [`MATMUL_ADRW-1:0] elemAddr(input logic [`MATMUL_ADRW-1:0] base,
                                                         input int row, input int col);
        return base + `MATMUL_ADRW'(4 * (row * DIM + col));
    endfunction

    // C(i,j) is the sum over k of A(i,k)*B(k,j), wrapping at 32 bits.
    function automatic logic [31:0] refMatmul(input matmulPkg::opMatrix_t a,
                                              input matmulPkg::opMatrix_t b,
                                              input int i, input int j);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < DIM; k++) begin
            sum = sum + 32'(a[i][k]) * 32'(b[k][j]);
        end
        return sum;
    endfunction

    task automatic randomMatrices(output matmulPkg::opMatrix_t a,
                                  output matmulPkg::opMatrix_t b);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                a[i][j] = 8'($random(seed));
                b[i][j] = 8'($random(seed));
            end
        end
    endtask

    task automatic loadMatrix(input logic [`MATMUL_ADRW-1:0] base,
                              input matmulPkg::opMatrix_t m, input string name);
        logic [31:0] junk;
        logic [31:0] rd;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                junk = $random(seed);
                wbWrite(elemAddr(base, i, j), {junk[31:8], m[i][j]}); // upper bits are dropped.
            end
        end
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                wbRead(elemAddr(base, i, j), rd);
                checkValue($sformatf("%s[%0d][%0d]", name, i, j), rd, {24'h0, m[i][j]});
            end
        end
    endtask

    task automatic checkResults(input matmulPkg::opMatrix_t a, input matmulPkg::opMatrix_t b);
        logic [31:0] rd;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                wbRead(elemAddr(matmulPkg::C_BASE, i, j), rd);
                checkValue($sformatf("C[%0d][%0d]", i, j), rd, refMatmul(a, b, i, j));
            end
        end
    endtask

    task automatic pollDone(output logic [31:0] st);
        int startCycle;
        bit finished;
        startCycle = cycleCount;
        finished   = 1'b0;
        st         = '0;
        while (!finished) begin
            wbRead(matmulPkg::STATUS_ADR, st);
            if (st[1]) begin
                finished = 1'b1;
            end else if (cycleCount - startCycle > POLL_TIMEOUT) begin
                $display("ERROR: done did not appear within %0d cycles", POLL_TIMEOUT);
                errors   = errors + 1;
                finished = 1'b1;
            end
        end
    endtask

    task automatic runProduct(input matmulPkg::opMatrix_t a, input matmulPkg::opMatrix_t b);
        logic [31:0] st;
        wbWrite(matmulPkg::CTRL_ADR, 32'h1);
        pollDone(st);
        checkValue("STATUS", st, 32'h2);
        checkResults(a, b);
    endtask

    initial begin
        wbIn  = '0;
        rst_n = 1'b0;
        aMat  = '0;
        bMat  = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        wbRead(matmulPkg::STATUS_ADR, status);
        checkValue("STATUS", status, 32'h0);
        checkResults(aMat, bMat); // zero operands give an all-zero C.

        randomMatrices(aMat, bMat);
        loadMatrix(matmulPkg::A_BASE, aMat, "A");
        loadMatrix(matmulPkg::B_BASE, bMat, "B");
        runProduct(aMat, bMat);

        // all operands at 255, so the sums carry well above 16 bits.
        aMat = '1;
        bMat = '1;
        loadMatrix(matmulPkg::A_BASE, aMat, "A");
        loadMatrix(matmulPkg::B_BASE, bMat, "B");
        runProduct(aMat, bMat);

        randomMatrices(aMat, bMat);
        loadMatrix(matmulPkg::A_BASE, aMat, "A");
        loadMatrix(matmulPkg::B_BASE, bMat, "B");
        wbWrite(matmulPkg::CTRL_ADR, 32'h1);
        startAck = ackCycle;
        repeat (2) begin
            wbRead(matmulPkg::STATUS_ADR, status);
            checkValue("STATUS", status, 32'h1);
        end
        wbWrite(matmulPkg::CTRL_ADR, 32'h1); // lands while the first run is still busy.
        pollDone(status);
        checkValue("STATUS", status, 32'h2);
        checkValue("doneInTime", 32'(ackCycle - startAck <= RUN_BOUND), 32'h1);
        checkResults(aMat, bMat);

        $display("tbMatmul: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
+incdir+verif
source/matmulPkg.sv
source/skewLine.sv
source/macCell.sv
source/systolicArray.sv
source/matmulSequencer.sv
source/matmulRegs.sv
source/matmulTop.sv
verif/tbMatmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it into sim.log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbMatmul -f tb.f \
    -Mdir obj_dir -o simMatmul

./obj_dir/simMatmul | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "run_sim.sh: simulation reported a failure"
    exit 1
fi
echo "run_sim.sh: simulation finished without failures"
